// File: include/av_macros.svh
`ifndef AV_MACROS_SVH
`define AV_MACROS_SVH

// address width of each camera buffer, so 2**3 = 8 pixels.
`define AV_FIFO_AW 3

// hsync pulse length in clock cycles.
`define AV_HSYNC_LEN 4

// completed output lines per buf_tick pulse.
`define AV_TICK_LINES 4

// cycles comb_err stays high after the last overflow.
`define AV_ERR_HOLD 64

`endif

// File: logic/av_pkg.sv
package av_pkg;

    // one RGB565 pixel, red in the top bits as the camera sends it.
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // the same pixel seen as the two bytes on the camera bus.
    typedef struct packed {
        logic [7:0] hi;     // first byte of a pixel on the bus.
        logic [7:0] lo;
    } byte_pair_t;

    // capture fills the byte view and the output stage reads the colour view.
    typedef union packed {
        rgb565_t    rgb;
        byte_pair_t bytes;
    } pixel_word_u;

endpackage : av_pkg

// File: logic/cam_capture.sv
`timescale 1ns/1ps

module cam_capture import av_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        vsync,
    input  logic        href,
    input  logic [7:0]  data,
    output logic        pix_valid,
    output pixel_word_u pix,
    output logic        line_end,
    output logic        frame_vsync
);

    logic       href_q;
    logic [7:0] data_q;
    logic       phase;      // set while the next byte is the low byte.
    logic [7:0] hi_byte;

    // the camera bus is registered once before any decoding.
    always_ff @(posedge clk) begin
        data_q <= data;
        if (rst) begin
            href_q <= 1'b0;
        end else begin
            href_q <= href;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= href_q && phase;
            if (href_q) begin
                phase <= ~phase;
            end else begin
                phase <= 1'b0;  // a new line always opens on a high byte.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (href_q && !phase) begin
            hi_byte <= data_q;
        end
        if (href_q && phase) begin
            pix.bytes.hi <= hi_byte;
            pix.bytes.lo <= data_q;
        end
    end

    // line_end marks the falling edge of href.
    always_ff @(posedge clk) begin
        if (rst) begin
            line_end    <= 1'b0;
            frame_vsync <= 1'b0;
        end else begin
            line_end    <= href_q && !href;
            frame_vsync <= vsync;
        end
    end

endmodule : cam_capture

// File: logic/pixel_fifo.sv
`timescale 1ns/1ps
`include "av_macros.svh"

module pixel_fifo import av_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  pixel_word_u din,
    input  logic        pop,
    output pixel_word_u dout,
    output logic        empty,
    output logic        full,
    output logic        overflow
);

    localparam int AW = `AV_FIFO_AW;
    localparam logic [AW:0] DEPTH = 1 << AW;

    pixel_word_u mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign empty    = (count == '0);
    assign full     = (count == DEPTH);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign overflow = push && full;     // the word is lost.
    assign dout     = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : pixel_fifo

// File: logic/pixel_combine.sv
`timescale 1ns/1ps
`include "av_macros.svh"

module pixel_combine import av_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        pix_valid_1,
    input  pixel_word_u pix_1,
    input  logic        line_end_1,
    input  logic        vsync_1,

    input  logic        pix_valid_2,
    input  pixel_word_u pix_2,

    output logic        valid,
    output pixel_word_u pixel_1,
    output pixel_word_u pixel_2,
    output logic        line_end,
    output logic        vsync,
    output logic        comb_err
);

    localparam int ERR_W = $clog2(`AV_ERR_HOLD + 1);

    pixel_word_u      dout_1;
    pixel_word_u      dout_2;
    logic             empty_1;
    logic             empty_2;
    logic             ovf_1;
    logic             ovf_2;
    logic             pop;
    logic             line_go;
    logic [1:0]       pend;     // camera 1 line ends still waiting for their pixels.
    logic [ERR_W-1:0] err_cnt;

    pixel_fifo u_fifo_1 (
        .clk     (clk        ),
        .rst     (rst        ),
        .push    (pix_valid_1),
        .din     (pix_1      ),
        .pop     (pop        ),
        .dout    (dout_1     ),
        .empty   (empty_1    ),
        .full    (           ),
        .overflow(ovf_1      )
    );

    pixel_fifo u_fifo_2 (
        .clk     (clk        ),
        .rst     (rst        ),
        .push    (pix_valid_2),
        .din     (pix_2      ),
        .pop     (pop        ),
        .dout    (dout_2     ),
        .empty   (empty_2    ),
        .full    (           ),
        .overflow(ovf_2      )
    );

    // a pair leaves only when both cameras have a pixel ready.
    assign pop = !empty_1 && !empty_2;

    // the line end goes out once its pixels have left camera 1's buffer.
    assign line_go = (pend != 2'd0) && empty_1;

    always_ff @(posedge clk) begin
        if (pop) begin
            pixel_1 <= dout_1;
            pixel_2 <= dout_2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= 1'b0;
            line_end <= 1'b0;
            vsync    <= 1'b0;
            pend     <= 2'd0;
        end else begin
            valid    <= pop;
            line_end <= line_go;
            vsync    <= vsync_1;
            case ({line_end_1, line_go})
                2'b10:   pend <= pend + 1'b1;
                2'b01:   pend <= pend - 1'b1;
                default: pend <= pend;
            endcase
        end
    end

    // error stretcher, reloaded by an overflow on either camera.
    always_ff @(posedge clk) begin
        if (rst) begin
            err_cnt <= '0;
        end else if (ovf_1 || ovf_2) begin
            err_cnt <= ERR_W'(`AV_ERR_HOLD);
        end else if (err_cnt != '0) begin
            err_cnt <= err_cnt - 1'b1;
        end
    end

    assign comb_err = (err_cnt != '0);

endmodule : pixel_combine

// File: logic/video_out.sv
`timescale 1ns/1ps
`include "av_macros.svh"

module video_out import av_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        valid,
    input  pixel_word_u pixel,
    input  logic        line_end,
    input  logic        vsync,
    output logic        hdmi_de,
    output logic [7:0]  hdmi_r,
    output logic [7:0]  hdmi_g,
    output logic [7:0]  hdmi_b,
    output logic        hdmi_hsync,
    output logic        hdmi_vsync,
    output logic        buf_tick
);

    localparam int HS_W = $clog2(`AV_HSYNC_LEN + 1);
    localparam int LN_W = $clog2(`AV_TICK_LINES + 1);

    logic [HS_W-1:0] hs_cnt;    // cycles of hsync left after the current one.
    logic [LN_W-1:0] ln_cnt;

    // each channel is padded with zeros below its RGB565 field.
    always_ff @(posedge clk) begin
        hdmi_r <= {pixel.rgb.red,   3'b000};
        hdmi_g <= {pixel.rgb.green, 2'b00};
        hdmi_b <= {pixel.rgb.blue,  3'b000};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdmi_de    <= 1'b0;
            hdmi_vsync <= 1'b0;
        end else begin
            hdmi_de    <= valid;
            hdmi_vsync <= vsync;
        end
    end

    // hsync opens on line_end and runs for AV_HSYNC_LEN cycles.
    always_ff @(posedge clk) begin
        if (rst) begin
            hs_cnt     <= '0;
            hdmi_hsync <= 1'b0;
        end else if (line_end) begin
            hs_cnt     <= HS_W'(`AV_HSYNC_LEN - 1);
            hdmi_hsync <= 1'b1;
        end else if (hs_cnt != '0) begin
            hs_cnt     <= hs_cnt - 1'b1;
            hdmi_hsync <= 1'b1;
        end else begin
            hdmi_hsync <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || vsync) begin
            ln_cnt   <= '0;     // the count restarts with every frame.
            buf_tick <= 1'b0;
        end else if (line_end) begin
            if (ln_cnt == LN_W'(`AV_TICK_LINES - 1)) begin
                ln_cnt   <= '0;
                buf_tick <= 1'b1;
            end else begin
                ln_cnt   <= ln_cnt + 1'b1;
                buf_tick <= 1'b0;
            end
        end else begin
            buf_tick <= 1'b0;
        end
    end

endmodule : video_out

// File: logic/dual_cam_top.sv
`timescale 1ns/1ps

module dual_cam_top import av_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       cam1_vsync,
    input  logic       cam1_href,
    input  logic [7:0] cam1_data,

    input  logic       cam2_vsync,
    input  logic       cam2_href,
    input  logic [7:0] cam2_data,

    output logic       hdmi_hsync,
    output logic       hdmi_vsync,
    output logic       hdmi_de,
    output logic [7:0] hdmi_r,
    output logic [7:0] hdmi_g,
    output logic [7:0] hdmi_b,
    output logic       buf_tick,
    output logic       comb_err
);

    logic        cap1_valid;
    pixel_word_u cap1_pix;
    logic        cap1_line_end;
    logic        cap1_vsync;
    logic        cap2_valid;
    pixel_word_u cap2_pix;

    logic        comb_valid;
    pixel_word_u comb_pix_1;
    logic        comb_line_end;
    logic        comb_vsync;

    cam_capture u_cap1 (
        .clk        (clk          ),
        .rst        (rst          ),
        .vsync      (cam1_vsync   ),
        .href       (cam1_href    ),
        .data       (cam1_data    ),
        .pix_valid  (cap1_valid   ),
        .pix        (cap1_pix     ),
        .line_end   (cap1_line_end),
        .frame_vsync(cap1_vsync   )
    );

    // camera 2 only supplies pixels, its line and frame timing follow camera 1.
    cam_capture u_cap2 (
        .clk        (clk       ),
        .rst        (rst       ),
        .vsync      (cam2_vsync),
        .href       (cam2_href ),
        .data       (cam2_data ),
        .pix_valid  (cap2_valid),
        .pix        (cap2_pix  ),
        .line_end   (          ),
        .frame_vsync(          )
    );

    pixel_combine u_combine (
        .clk        (clk          ),
        .rst        (rst          ),
        .pix_valid_1(cap1_valid   ),
        .pix_1      (cap1_pix     ),
        .line_end_1 (cap1_line_end),
        .vsync_1    (cap1_vsync   ),
        .pix_valid_2(cap2_valid   ),
        .pix_2      (cap2_pix     ),
        .valid      (comb_valid   ),
        .pixel_1    (comb_pix_1   ),
        .pixel_2    (             ),
        .line_end   (comb_line_end),
        .vsync      (comb_vsync   ),
        .comb_err   (comb_err     )
    );

    video_out u_out (
        .clk       (clk          ),
        .rst       (rst          ),
        .valid     (comb_valid   ),
        .pixel     (comb_pix_1   ),
        .line_end  (comb_line_end),
        .vsync     (comb_vsync   ),
        .hdmi_de   (hdmi_de      ),
        .hdmi_r    (hdmi_r       ),
        .hdmi_g    (hdmi_g       ),
        .hdmi_b    (hdmi_b       ),
        .hdmi_hsync(hdmi_hsync   ),
        .hdmi_vsync(hdmi_vsync   ),
        .buf_tick  (buf_tick     )
    );

endmodule : dual_cam_top

// File: bench/dual_cam_checker.sv
`timescale 1ns/1ps
`include "av_macros.svh"

module dual_cam_checker (
    input logic       clk,
    input logic       rst,
    input logic       hdmi_hsync,
    input logic       hdmi_vsync,
    input logic       hdmi_de,
    input logic [7:0] hdmi_r,
    input logic [7:0] hdmi_g,
    input logic [7:0] hdmi_b,
    input logic       buf_tick,
    input logic       comb_err
);

    logic [7:0] hs_run;     // high samples seen so far in the current hsync pulse.

    always_ff @(posedge clk) begin
        if (rst || !hdmi_hsync) begin
            hs_run <= 8'd0;
        end else if (hs_run != 8'hff) begin
            hs_run <= hs_run + 8'd1;
        end
    end

    hsync_not_long: assert property (@(posedge clk) disable iff (rst)
        hdmi_hsync |-> hs_run < 8'(`AV_HSYNC_LEN))
        else $error("hdmi_hsync stayed high longer than its pulse length");

    hsync_not_short: assert property (@(posedge clk) disable iff (rst)
        $fell(hdmi_hsync) |-> hs_run == 8'(`AV_HSYNC_LEN))
        else $error("hdmi_hsync pulse ended early");

    de_outside_hsync: assert property (@(posedge clk) disable iff (rst)
        !(hdmi_de && hdmi_hsync))
        else $error("hdmi_de high during hdmi_hsync");

    control_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({hdmi_hsync, hdmi_vsync, hdmi_de, buf_tick, comb_err}))
        else $error("video control output is unknown");

    // colour outputs carry meaning only with a data beat.
    colour_known: assert property (@(posedge clk) disable iff (rst)
        hdmi_de |-> !$isunknown({hdmi_r, hdmi_g, hdmi_b}))
        else $error("colour output unknown during a data beat");

endmodule : dual_cam_checker

// File: bench/tb_dual_cam.sv
`timescale 1ns/1ps
`include "av_macros.svh"

module tb_dual_cam;

    localparam int DEPTH      = 1 << `AV_FIFO_AW;
    localparam int WAIT_LIMIT = 500;    // cycles any single wait may take.

    logic       clk;
    logic       rst;
    logic       cam1_vsync;
    logic       cam1_href;
    logic [7:0] cam1_data;
    logic       cam2_vsync;
    logic       cam2_href;
    logic [7:0] cam2_data;
    logic       hdmi_hsync;
    logic       hdmi_vsync;
    logic       hdmi_de;
    logic [7:0] hdmi_r;
    logic [7:0] hdmi_g;
    logic [7:0] hdmi_b;
    logic       buf_tick;
    logic       comb_err;

    logic [15:0] cam1_q[$];
    logic [15:0] cam2_q[$];

    int   beats;
    int   total_pix;
    int   lines_sent;
    int   model_lines;      // lines since the last tick or frame start.
    int   exp_ticks;
    int   hsync_count;
    int   beats_at_hsync;
    int   tick_count;
    logic hsync_q;
    logic err_seen;
    logic check_values;

    bind dual_cam_top dual_cam_checker u_checker (.*);

    dual_cam_top i_dual_cam_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // rgb565 to 24-bit colour, each field padded with zeros below.
    function automatic logic [23:0] expand_rgb(input logic [15:0] w);
        return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic abort(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic drive_cam1_line(input int n_pix, input int offset);
        logic [15:0] px;
        repeat (2 * offset) @(posedge clk);
        for (int i = 0; i < n_pix; i++) begin
            px = 16'($urandom);
            cam1_q.push_back(px);
            @(posedge clk);
            cam1_href <= 1'b1;
            cam1_data <= px[15:8];      // high byte goes first.
            @(posedge clk);
            cam1_data <= px[7:0];
        end
        @(posedge clk);
        cam1_href <= 1'b0;
        cam1_data <= 8'h00;
    endtask

    task automatic drive_cam2_line(input int n_pix, input int offset);
        logic [15:0] px;
        repeat (2 * offset) @(posedge clk);
        for (int i = 0; i < n_pix; i++) begin
            px = 16'($urandom);
            cam2_q.push_back(px);
            @(posedge clk);
            cam2_href <= 1'b1;
            cam2_data <= px[15:8];
            @(posedge clk);
            cam2_data <= px[7:0];
        end
        @(posedge clk);
        cam2_href <= 1'b0;
        cam2_data <= 8'h00;
    endtask

    task automatic wait_hsyncs(input int target);
        int n;
        n = 0;
        while (hsync_count < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (hsync_count < target) begin
            abort("timeout waiting for the hsync pulse at the end of a line");
        end
    endtask

    // one line from each camera, camera 2 starting skew pixels later.
    task automatic run_line(input int n_pix, input int skew, input logic clean);
        fork
            drive_cam1_line(n_pix, 0);
            drive_cam2_line(n_pix, skew);
        join
        total_pix += n_pix;
        lines_sent++;
        model_lines++;
        if (model_lines == `AV_TICK_LINES) begin
            model_lines = 0;
            exp_ticks++;
        end
        wait_hsyncs(lines_sent);
        if (clean) begin
            check("hdmi_de beats before hsync", beats_at_hsync, total_pix);
            check("comb_err seen", 32'(err_seen), 0);
        end
        check("buf_tick pulses", tick_count, exp_ticks);
        repeat (4) @(posedge clk);
        check("hdmi_hsync pulses", hsync_count, lines_sent);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (hdmi_hsync && !hsync_q) begin
                hsync_count++;
                beats_at_hsync = beats;
            end
            if (buf_tick) begin
                tick_count++;
            end
            if (comb_err) begin
                err_seen = 1'b1;
            end
        end
        hsync_q = hdmi_hsync;
    end

    always @(posedge clk) begin : compare_beats
        logic [15:0] px1;
        logic [23:0] exp_rgb;
        if (!rst && hdmi_de) begin
            if (cam1_q.size() == 0) begin
                abort("hdmi_de beat with no camera 1 pixel pending");
            end else begin
                px1 = cam1_q.pop_front();
                if (cam2_q.size() != 0) begin
                    void'(cam2_q.pop_front());  // keeps the pairing order only.
                end
                beats++;
                if (check_values) begin
                    exp_rgb = expand_rgb(px1);
                    check("hdmi_r", 32'(hdmi_r), 32'(exp_rgb[23:16]));
                    check("hdmi_g", 32'(hdmi_g), 32'(exp_rgb[15:8]));
                    check("hdmi_b", 32'(hdmi_b), 32'(exp_rgb[7:0]));
                end
            end
        end
    end

    initial begin
        int n;
        int ticks_before;
        int beats_before;
        void'($urandom(32'hb542_ff5f));
        rst          = 1'b1;
        cam1_vsync   = 1'b0;
        cam1_href    = 1'b0;
        cam1_data    = 8'h00;
        cam2_vsync   = 1'b0;
        cam2_href    = 1'b0;
        cam2_data    = 8'h00;
        beats        = 0;
        total_pix    = 0;
        lines_sent   = 0;
        model_lines  = 0;
        exp_ticks    = 0;
        hsync_count  = 0;
        tick_count   = 0;
        err_seen     = 1'b0;
        check_values = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        run_line(12, 0, 1'b1);              // both cameras in step.
        run_line(12, 0, 1'b1);
        run_line(12, 3, 1'b1);
        run_line(12, DEPTH - 1, 1'b1);      // the latest start one buffer still covers.

        ticks_before = tick_count;
        for (int i = 0; i < 8; i++) begin
            run_line(8 + i, i, 1'b1);
        end
        check("buf_tick pulses over 8 lines", tick_count - ticks_before, 8 / `AV_TICK_LINES);

        // leave the line count part way, then open a new frame.
        run_line(6, 0, 1'b1);
        run_line(6, 0, 1'b1);
        @(posedge clk);
        cam1_vsync <= 1'b1;
        cam2_vsync <= 1'b1;
        n = 0;
        while (!hdmi_vsync && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!hdmi_vsync) begin
            abort("timeout waiting for hdmi_vsync to rise");
        end else begin
            check("hdmi_vsync delay", n, 4);    // one sampling edge and three stages.
        end
        repeat (4) @(posedge clk);
        cam1_vsync <= 1'b0;
        cam2_vsync <= 1'b0;
        n = 0;
        while (hdmi_vsync && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (hdmi_vsync) begin
            abort("timeout waiting for hdmi_vsync to fall");
        end
        model_lines = 0;
        for (int i = 0; i < `AV_TICK_LINES; i++) begin
            run_line(6, 1, 1'b1);
        end

        // camera 2 starts later than a full buffer can cover.
        check_values = 1'b0;
        err_seen     = 1'b0;
        beats_before = beats;
        run_line(16, DEPTH + 4, 1'b0);
        check("comb_err seen", 32'(err_seen), 1);
        if (beats - beats_before >= 16) begin
            abort("overflow line gave an output beat for every camera 1 pixel");
        end
        n = 0;
        while (comb_err && n < `AV_ERR_HOLD + 16) begin
            @(negedge clk);
            n++;
        end
        check("comb_err", 32'(comb_err), 0);

        $display("TEST OK");
        $finish;
    end

endmodule : tb_dual_cam

// File: tb.f
+incdir+include
logic/av_pkg.sv
logic/cam_capture.sv
logic/pixel_fifo.sv
logic/pixel_combine.sv
logic/video_out.sv
logic/dual_cam_top.sv
bench/dual_cam_checker.sv
bench/tb_dual_cam.sv

// File: Makefile
TOP := tb_dual_cam

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
